// ==== list.f ====
+incdir+include
src/coder_pkg.sv
src/stream_pkg.sv
src/carry_resolver.sv
src/pending_buffer.sv
src/byte_packer.sv
src/carry_output_top.sv
testbench/tb_carry_output.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the carry output testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f list.f \
    --top-module tb_carry_output \
    --Mdir obj_dir -o sim_carry_output \
    || { echo "Verilator build failed"; exit 1; }

sim_output=$(./obj_dir/sim_carry_output)
echo "$sim_output"
echo "$sim_output" | grep -q "TESTS PASSED" && exit 0 || exit 1

// ==== src/byte_packer.sv ====
// Committed byte packer

`timescale 1ns/1ns

module byte_packer (
    input  logic                     clk,
    input  logic                     reset,
    input  stream_pkg::lane_count_t  committed_count,
    input  coder_pkg::byte_t         committed_bytes [stream_pkg::OUT_LANES],
    output stream_pkg::lane_count_t  pop_count,
    output logic                     out_valid,
    output stream_pkg::out_word_t    out_word,
    input  logic                     out_ready
);

    import stream_pkg::*;

    logic load;

    // Register is empty or its word is taken on this edge
    assign load = !out_valid || out_ready;

    // Take everything offered, the buffer already caps it at OUT_LANES
    assign pop_count = load ? committed_count : lane_count_t'(0);

    // ========================================
    // Output register
    // ========================================

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (load) begin
            out_valid <= (committed_count != lane_count_t'(0));
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            out_word.count <= committed_count;
            for (int k = 0; k < OUT_LANES; k++) begin
                // Lanes beyond the count are cleared
                if (k < int'(committed_count)) begin
                    out_word.lanes[k] <= committed_bytes[k];
                end else begin
                    out_word.lanes[k] <= '0;
                end
            end
        end
    end

endmodule

// ==== src/carry_output_top.sv ====
// Carry resolving byte output stage

`timescale 1ns/1ns

module carry_output_top #(
    parameter int BUFFER_DEPTH = 16
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   in_valid,
    input  coder_pkg::symbol_t     in_symbol,
    input  logic                   flush_valid,
    output logic                   in_ready,
    output logic                   out_valid,
    output stream_pkg::out_word_t  out_word,
    input  logic                   out_ready
);

    import coder_pkg::*;
    import stream_pkg::*;

    logic        op_valid;
    buffer_op_t  op;
    logic        op_ready;
    lane_count_t committed_count;
    byte_t       committed_bytes [OUT_LANES];
    lane_count_t pop_count;

    // ========================================
    // Stages
    // ========================================

    carry_resolver u_carry_resolver (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (in_valid),
        .in_symbol   (in_symbol),
        .flush_valid (flush_valid),
        .in_ready    (in_ready),
        .op_valid    (op_valid),
        .op          (op),
        .op_ready    (op_ready)
    );

    pending_buffer #(
        .BUFFER_DEPTH (BUFFER_DEPTH)
    ) u_pending_buffer (
        .clk             (clk),
        .reset           (reset),
        .op_valid        (op_valid),
        .op              (op),
        .op_ready        (op_ready),
        .committed_count (committed_count),
        .committed_bytes (committed_bytes),
        .pop_count       (pop_count)
    );

    byte_packer u_byte_packer (
        .clk             (clk),
        .reset           (reset),
        .committed_count (committed_count),
        .committed_bytes (committed_bytes),
        .pop_count       (pop_count),
        .out_valid       (out_valid),
        .out_word        (out_word),
        .out_ready       (out_ready)
    );

endmodule

// ==== src/carry_resolver.sv ====
// Symbol to buffer operation stage

`timescale 1ns/1ns

module carry_resolver (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   in_valid,
    input  coder_pkg::symbol_t     in_symbol,
    input  logic                   flush_valid,
    output logic                   in_ready,
    output logic                   op_valid,
    output coder_pkg::buffer_op_t  op,
    input  logic                   op_ready
);

    import coder_pkg::*;

    localparam buffer_op_t FLUSH_OP = '{
        add_carry:     1'b0,
        append:        1'b0,
        commit_before: 1'b0,
        flush:         1'b1,
        code_byte:     '0
    };

    logic       load_en;
    logic       flush_pending;
    buffer_op_t sym_op;

    // Stage is free, or its operation leaves on this edge
    assign load_en  = !op_valid || op_ready;

    // A flush that arrived with a symbol goes out right after it
    assign in_ready = load_en && !flush_pending;

    // ========================================
    // Symbol decode
    // ========================================

    always_comb begin
        sym_op               = '0;
        sym_op.add_carry     = in_symbol.carry;
        sym_op.append        = 1'b1;
        // A non-saturated byte ends any open run before it
        sym_op.commit_before = (in_symbol.code_byte != BYTE_SATURATED);
        sym_op.code_byte     = in_symbol.code_byte;
    end

    // ========================================
    // Operation register
    // ========================================

    always_ff @(posedge clk) begin
        if (reset) begin
            op_valid      <= 1'b0;
            flush_pending <= 1'b0;
        end else if (load_en) begin
            op_valid      <= flush_pending || in_valid || flush_valid;
            flush_pending <= !flush_pending && in_valid && flush_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (load_en) begin
            if (flush_pending || !in_valid) begin
                op <= FLUSH_OP;
            end else begin
                op <= sym_op;
            end
        end
    end

endmodule

// ==== src/coder_pkg.sv ====
// Coder input side types

package coder_pkg;

    // ========================================
    // Coded bytes
    // ========================================

    typedef logic [7:0] byte_t;

    // A byte of this value keeps a pending run open
    localparam byte_t BYTE_SATURATED = 8'd255;

    // One input symbol from the arithmetic coder
    typedef struct packed {
        logic  carry;       // Add 1 to everything emitted so far
        byte_t code_byte;
    } symbol_t;

    // ========================================
    // Buffer operation
    // ========================================

    // Carry is applied first, then the append, then the commit move
    typedef struct packed {
        logic  add_carry;
        logic  append;
        logic  commit_before;   // Commit every entry before the new one
        logic  flush;           // Commit every entry, new one included
        byte_t code_byte;
    } buffer_op_t;

endpackage

// ==== src/pending_buffer.sv ====
// Pending and committed byte buffer

`timescale 1ns/1ns

module pending_buffer #(
    parameter int BUFFER_DEPTH = 16
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     op_valid,
    input  coder_pkg::buffer_op_t    op,
    output logic                     op_ready,
    output stream_pkg::lane_count_t  committed_count,
    output coder_pkg::byte_t         committed_bytes [stream_pkg::OUT_LANES],
    input  stream_pkg::lane_count_t  pop_count
);

    import coder_pkg::*;
    import stream_pkg::*;

    localparam int PTR_W = $clog2(BUFFER_DEPTH);

    // Pointers carry one extra wrap bit so full and empty differ
    typedef logic [PTR_W:0]   ptr_t;
    typedef logic [PTR_W-1:0] idx_t;

    byte_t mem [BUFFER_DEPTH];

    // rd_ptr .. cm_ptr is committed, cm_ptr .. wr_ptr is pending
    ptr_t rd_ptr;
    ptr_t cm_ptr;
    ptr_t wr_ptr;

    ptr_t committed_len;
    ptr_t pending_len;
    ptr_t used_len;
    idx_t rd_idx;
    idx_t cm_idx;
    idx_t wr_idx;
    logic accept;

    // Indexed by offset from the commit pointer
    logic [BUFFER_DEPTH-1:0] sat_vec;
    logic [BUFFER_DEPTH-1:0] carry_hit;

    assign committed_len = cm_ptr - rd_ptr;
    assign pending_len   = wr_ptr - cm_ptr;
    assign used_len      = wr_ptr - rd_ptr;
    assign rd_idx        = rd_ptr[PTR_W-1:0];
    assign cm_idx        = cm_ptr[PTR_W-1:0];
    assign wr_idx        = wr_ptr[PTR_W-1:0];

    // Only an append needs a free entry
    assign op_ready = !(op.append && (used_len == ptr_t'(BUFFER_DEPTH)));
    assign accept   = op_valid && op_ready;

    // ========================================
    // Committed side
    // ========================================

    assign committed_count = (committed_len > ptr_t'(OUT_LANES)) ?
                             lane_count_t'(OUT_LANES) : lane_count_t'(committed_len);

    always_comb begin
        for (int k = 0; k < OUT_LANES; k++) begin
            committed_bytes[k] = mem[rd_idx + idx_t'(k)];
        end
    end

    // ========================================
    // Carry rule
    // ========================================

    // Entries past the pending region count as saturated so they never block
    always_comb begin
        for (int k = 0; k < BUFFER_DEPTH; k++) begin
            sat_vec[k] = (k >= int'(pending_len)) ||
                         (mem[cm_idx + idx_t'(k)] == BYTE_SATURATED);
        end
    end

    // Entry k takes the carry when every later entry is saturated
    always_comb begin
        logic [BUFFER_DEPTH-1:0] above;
        for (int k = 0; k < BUFFER_DEPTH; k++) begin
            above        = {BUFFER_DEPTH{1'b1}} << (k + 1);
            carry_hit[k] = (k < int'(pending_len)) && (&(sat_vec | ~above));
        end
    end

    // Carry out of the oldest pending byte simply wraps away
    always_ff @(posedge clk) begin
        if (accept) begin
            for (int i = 0; i < BUFFER_DEPTH; i++) begin
                if (op.add_carry && carry_hit[idx_t'(i) - cm_idx]) begin
                    mem[i] <= mem[i] + byte_t'(1);
                end
            end
            if (op.append) begin
                mem[wr_idx] <= op.code_byte;
            end
        end
    end

    // ========================================
    // Pointers
    // ========================================

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr <= '0;
            cm_ptr <= '0;
            wr_ptr <= '0;
        end else begin
            rd_ptr <= rd_ptr + ptr_t'(pop_count);
            if (accept) begin
                if (op.append) begin
                    wr_ptr <= wr_ptr + ptr_t'(1);
                end
                if (op.flush) begin
                    cm_ptr <= wr_ptr + ptr_t'(op.append);
                end else if (op.commit_before) begin
                    cm_ptr <= wr_ptr;
                end
            end
        end
    end

endmodule

// ==== src/stream_pkg.sv ====
// Output stream types

package stream_pkg;

    // ========================================
    // Output word
    // ========================================

    // Most bytes carried by one output word
    localparam int OUT_LANES = 4;

    // Count of valid lanes, 0 to OUT_LANES
    typedef logic [2:0] lane_count_t;

    // Lane 0 holds the oldest byte
    // Lanes at or above count read as zero
    typedef struct packed {
        lane_count_t                         count;
        coder_pkg::byte_t [OUT_LANES-1:0]    lanes;
    } out_word_t;

endpackage

// ==== include/tb_vectors.svh ====
// Carry output test vectors

`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// One row per input step, a symbol or a flush
// Columns are test_id, is_flush, carry, code_byte, released
// Released counts the bytes of this test committed once the step has taken effect
typedef struct packed {
    logic [3:0] test_id;
    logic       is_flush;
    logic       carry;
    byte_t      code_byte;
    logic [7:0] released;
} step_t;

// Columns are test_id, code_byte, in output order
typedef struct packed {
    logic [3:0] test_id;
    byte_t      code_byte;
} expect_t;

localparam int NUM_STEPS    = 43;
localparam int NUM_EXPECTED = 35;

function automatic string test_name(input int id);
    case (id)
        0:       return "plain_bytes";
        1:       return "saturated_run";
        2:       return "carry_through_run";
        3:       return "carry_makes_255";
        4:       return "carry_on_new_255";
        5:       return "flush_run";
        6:       return "carry_after_flush";
        7:       return "long_carry_run";
        default: return "unknown";
    endcase
endfunction

// ========================================
// Stimulus
// ========================================

localparam step_t STEPS [NUM_STEPS] = '{
    '{0, 0, 0, 1, 0}, '{0, 0, 0, 2, 1}, '{0, 0, 0, 3, 2}, '{0, 0, 0, 4, 3},
    '{0, 0, 0, 5, 4}, '{0, 0, 0, 6, 5}, '{0, 1, 0, 0, 6},
    '{1, 0, 0, 10, 0}, '{1, 0, 0, 255, 0}, '{1, 0, 0, 255, 0}, '{1, 0, 0, 7, 3},
    '{1, 1, 0, 0, 4},
    // Carry ripples through the run into the 10
    '{2, 0, 0, 10, 0}, '{2, 0, 0, 255, 0}, '{2, 0, 0, 255, 0}, '{2, 0, 1, 7, 3},
    '{2, 1, 0, 0, 4},
    '{3, 0, 0, 40, 0}, '{3, 0, 0, 254, 1}, '{3, 0, 1, 6, 2}, '{3, 1, 0, 0, 3},
    // 254 becomes a pending 255, next carry wraps it and is dropped
    '{4, 0, 0, 40, 0}, '{4, 0, 0, 254, 1}, '{4, 0, 1, 255, 1}, '{4, 0, 1, 9, 3},
    '{4, 1, 0, 0, 4},
    '{5, 0, 0, 5, 0}, '{5, 0, 0, 255, 0}, '{5, 0, 0, 255, 0}, '{5, 1, 0, 0, 3},
    // Nothing is pending after a flush so the first carry is lost
    '{6, 0, 1, 8, 0}, '{6, 0, 0, 200, 1}, '{6, 0, 1, 30, 2}, '{6, 1, 0, 0, 3},
    '{7, 0, 0, 3, 0}, '{7, 0, 0, 255, 0}, '{7, 0, 0, 255, 0}, '{7, 0, 0, 255, 0},
    '{7, 0, 0, 255, 0}, '{7, 0, 0, 255, 0}, '{7, 0, 0, 255, 0}, '{7, 0, 1, 2, 7},
    '{7, 1, 0, 0, 8}
};

// ========================================
// Expected output bytes
// ========================================

localparam expect_t EXPECTED [NUM_EXPECTED] = '{
    '{0, 1}, '{0, 2}, '{0, 3}, '{0, 4}, '{0, 5}, '{0, 6},
    '{1, 10}, '{1, 255}, '{1, 255}, '{1, 7},
    '{2, 11}, '{2, 0}, '{2, 0}, '{2, 7},
    '{3, 40}, '{3, 255}, '{3, 6},
    '{4, 40}, '{4, 0}, '{4, 0}, '{4, 9},
    '{5, 5}, '{5, 255}, '{5, 255},
    '{6, 8}, '{6, 201}, '{6, 30},
    '{7, 4}, '{7, 0}, '{7, 0}, '{7, 0}, '{7, 0}, '{7, 0}, '{7, 0}, '{7, 2}
};

`endif

// ==== testbench/tb_carry_output.sv ====
// Carry output stage testbench

`timescale 1ns/1ns

module tb_carry_output;

    import coder_pkg::*;
    import stream_pkg::*;

    `include "tb_vectors.svh"

    // Two passes over the table, 20 cycles per step, plus reset and idle time
    localparam int TIMEOUT_CYCLES = 2 * NUM_STEPS * 20 + 100;

    logic      clk;
    logic      reset;
    logic      in_valid;
    symbol_t   in_symbol;
    logic      flush_valid;
    logic      in_ready;
    logic      out_valid;
    out_word_t out_word;
    logic      out_ready;

    logic        random_ready;
    int          seed;
    logic [31:0] rnd;
    int          rx_count;
    int          cycle_count;

    carry_output_top #(
        .BUFFER_DEPTH (16)
    ) dut (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (in_valid),
        .in_symbol   (in_symbol),
        .flush_valid (flush_valid),
        .in_ready    (in_ready),
        .out_valid   (out_valid),
        .out_word    (out_word),
        .out_ready   (out_ready)
    );

    always #2 clk = ~clk;

    // ========================================
    // Helpers
    // ========================================

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("TESTS FAILED");
        $fatal(1, "Simulation stopped on error");
    endtask

    // Number of expected bytes that belong to tests before this one
    function automatic int bytes_before(input int id);
        int count;
        count = 0;
        for (int i = 0; i < NUM_EXPECTED; i++) begin
            if (int'(EXPECTED[i].test_id) < id) begin
                count++;
            end
        end
        return count;
    endfunction

    task automatic check_byte(input byte_t actual);
        expect_t want;
        assert (rx_count < NUM_EXPECTED)
            else fail_run("Output byte arrived after every expected byte");
        want = EXPECTED[rx_count];
        assert (actual == want.code_byte)
            else fail_run($sformatf("FAILED %s/%s expected %0d actual %0d",
                                    test_name(int'(want.test_id)),
                                    random_ready ? "random_ready" : "steady_ready",
                                    want.code_byte, actual));
        rx_count++;
    endtask

    // Lanes at or above the count read as zero
    // Called after the valid lanes of the same word, so rx_count is at least 1
    task automatic verify_lane_cleared(input int lane, input byte_t actual);
        expect_t last;
        last = EXPECTED[rx_count - 1];
        assert (actual == '0)
            else fail_run($sformatf("FAILED %s/%s lane %0d expected 0 actual %0d",
                                    test_name(int'(last.test_id)),
                                    random_ready ? "random_ready" : "steady_ready",
                                    lane, actual));
    endtask

    // Starts and ends at 1 ns after a rising edge
    task automatic apply_step(input step_t step, input int bound, input int test_start);
        logic taken;
        in_symbol.carry     = step.carry;
        in_symbol.code_byte = step.code_byte;
        in_valid            = !step.is_flush;
        flush_valid         = step.is_flush;
        taken               = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = in_ready;
            @(posedge clk);
            #1;
        end
        in_valid    = 1'b0;
        flush_valid = 1'b0;
        // Bytes still pending must not have left the stage yet
        assert (rx_count - test_start <= bound)
            else fail_run("Bytes left the stage before a later byte committed them");
    endtask

    task automatic wait_for_bytes(input int target);
        while (rx_count < target) begin
            @(posedge clk);
            #1;
        end
    endtask

    // ========================================
    // Output side
    // ========================================

    always @(posedge clk) begin
        #1;
        if (random_ready) begin
            rnd       = $random(seed);
            out_ready = rnd[0];
        end else begin
            out_ready = 1'b1;
        end
    end

    // A word is taken on the edge after this sample
    always @(negedge clk) begin
        if (!reset && out_valid && out_ready) begin
            assert (out_word.count != '0 && out_word.count <= lane_count_t'(OUT_LANES))
                else fail_run("Output word carries an invalid byte count");
            for (int k = 0; k < OUT_LANES; k++) begin
                if (k < int'(out_word.count)) begin
                    check_byte(out_word.lanes[k]);
                end else begin
                    verify_lane_cleared(k, out_word.lanes[k]);
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            fail_run("Timeout waiting for the DUT");
        end
    end

    // ========================================
    // Main sequence
    // ========================================

    initial begin
        int prior_released;
        int test_start;
        int cur_test;
        clk          = 1'b0;
        reset        = 1'b1;
        in_valid     = 1'b0;
        in_symbol    = '0;
        flush_valid  = 1'b0;
        out_ready    = 1'b1;
        random_ready = 1'b0;
        seed         = 43;
        rx_count     = 0;
        cycle_count  = 0;

        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        @(negedge clk);
        assert (!out_valid && in_ready)
            else fail_run("After reset out_valid is not low or in_ready is not high");
        @(posedge clk);
        #1;

        // First pass with a steady sink, second with random back-pressure
        for (int pass = 0; pass < 2; pass++) begin
            random_ready   = (pass == 1);
            rx_count       = 0;
            cur_test       = -1;
            prior_released = 0;
            test_start     = 0;
            for (int s = 0; s < NUM_STEPS; s++) begin
                if (int'(STEPS[s].test_id) != cur_test) begin
                    cur_test       = int'(STEPS[s].test_id);
                    prior_released = 0;
                    test_start     = bytes_before(cur_test);
                end
                apply_step(STEPS[s], prior_released, test_start);
                prior_released = int'(STEPS[s].released);
                if (s == NUM_STEPS - 1 || int'(STEPS[s + 1].test_id) != cur_test) begin
                    wait_for_bytes(bytes_before(cur_test + 1));
                end
            end
        end

        // Idle window so a stray extra byte would still be caught
        repeat (20) @(posedge clk);
        if (rx_count == NUM_EXPECTED) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            fail_run("Byte count at the end of the run does not match the table");
        end
    end

endmodule
